// File: source/cpuSettings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// register and alu word
`define DATA_WIDTH 32

// register index, 32 entries
`define REG_ADDR_WIDTH 5

// immediate field of the i-type format
`define IMM_WIDTH 16

// shift amount field of the r-type format
`define SHAMT_WIDTH 5

// opcode field, bits 31:26
`define OPCODE_WIDTH 6

// funct field, bits 5:0
`define FUNCT_WIDTH 6

`endif

// File: source/cpuPkg.sv
`default_nettype none
`include "cpuSettings.svh"

package cpuPkg;

	typedef logic [`DATA_WIDTH-1:0] wordT; // datapath word
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT; // register index

	// field order follows bit order, msb first
	typedef struct packed {
		logic [`OPCODE_WIDTH-1:0] opcode; // 31:26
		regAddrT rs; // 25:21
		regAddrT rt; // 20:16
		regAddrT rd; // 15:11, top of imm
		logic [`SHAMT_WIDTH-1:0] shamt; // 10:6
		logic [`FUNCT_WIDTH-1:0] funct; // 5:0, bottom of imm
	} instrT;

	typedef enum logic [`OPCODE_WIDTH-1:0] {
		RTYPE = 6'h00, // op in funct
		ADDI = 6'h08,
		ADDIU = 6'h09,
		SLTI = 6'h0a,
		SLTIU = 6'h0b,
		ANDI = 6'h0c,
		ORI = 6'h0d,
		XORI = 6'h0e,
		LUI = 6'h0f,
		HALT = 6'h3f // stops writeback for good
	} opcodeT;

	typedef enum logic [`FUNCT_WIDTH-1:0] {
		SLL = 6'h00,
		SRL = 6'h02,
		ADD = 6'h20,
		ADDU = 6'h21,
		SUB = 6'h22,
		SUBU = 6'h23,
		AND = 6'h24,
		OR = 6'h25,
		XOR = 6'h26,
		NOR = 6'h27,
		SLT = 6'h2a,
		SLTU = 6'h2b
	} functT;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_NOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL
	} aluOpT;

	typedef enum logic [1:0] {
		SEL_REG, // rt value
		SEL_SHAMT, // zero-extended shamt
		SEL_IMM // extended immediate
	} operandSelT;

	typedef struct packed {
		aluOpT aluOp;
		operandSelT operandSel; // alu operand b source
		logic regWrite;
		logic isLui; // imm to upper half, alu bypassed
		logic isHalt;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		regAddrT rs;
		regAddrT rt;
		regAddrT destReg; // rd or rt by format
		wordT immExt; // sign or zero extended per opcode
	} decodedT;

	typedef struct packed {
		logic wen; // a register was written
		regAddrT destReg;
		wordT value;
	} resultT;

	typedef enum logic [1:0] {IDLE, EXEC, DONE} coreStateT;

endpackage

`default_nettype wire

// File: source/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpuSettings.svh"

module instrDecoder
	import cpuPkg::*;
(
	input instrT instr, // held stable by the core
	output decodedT decoded
);

	opcodeT opcode;
	functT funct;
	logic [`IMM_WIDTH-1:0] imm;
	logic signExt; // arithmetic and compare immediates
	wordT immExt;
	regAddrT destReg;
	ctrlT ctrl;

	// one table row in one line
	function automatic ctrlT mkCtrl(
		input aluOpT op,
		input operandSelT sel,
		input logic wr,
		input logic lui,
		input logic halt
	);
		ctrlT c;
		c.aluOp = op;
		c.operandSel = sel;
		c.regWrite = wr;
		c.isLui = lui;
		c.isHalt = halt;
		return c;
	endfunction

	assign opcode = opcodeT'(instr.opcode); // may hold an unlisted code
	assign funct = functT'(instr.funct); // same for funct

	// i-type immediate overlaps rd, shamt and funct
	assign imm = {instr.rd, instr.shamt, instr.funct};

	assign signExt = opcode inside {ADDI, ADDIU, SLTI, SLTIU};

	assign immExt = signExt ?
		{{(`DATA_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm} : // replicate sign
		{{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm}; // logic ops and lui

	assign destReg = (opcode == RTYPE) ? instr.rd : instr.rt; // r-type writes rd

	always_comb
	begin
		// anything not listed falls through as a no-op
		ctrl = mkCtrl(ALU_ADD, SEL_REG, 1'b0, 1'b0, 1'b0);
		casez ({opcode, funct})
			// r-type, funct picks the op
			{RTYPE, SLL}:
				ctrl = mkCtrl(ALU_SLL, SEL_SHAMT, 1'b1, 1'b0, 1'b0); // rt << shamt
			{RTYPE, SRL}:
				ctrl = mkCtrl(ALU_SRL, SEL_SHAMT, 1'b1, 1'b0, 1'b0); // logical
			{RTYPE, ADD}:
				ctrl = mkCtrl(ALU_ADD, SEL_REG, 1'b1, 1'b0, 1'b0); // no overflow trap
			{RTYPE, ADDU}:
				ctrl = mkCtrl(ALU_ADD, SEL_REG, 1'b1, 1'b0, 1'b0);
			{RTYPE, SUB}:
				ctrl = mkCtrl(ALU_SUB, SEL_REG, 1'b1, 1'b0, 1'b0); // no overflow trap
			{RTYPE, SUBU}:
				ctrl = mkCtrl(ALU_SUB, SEL_REG, 1'b1, 1'b0, 1'b0);
			{RTYPE, AND}:
				ctrl = mkCtrl(ALU_AND, SEL_REG, 1'b1, 1'b0, 1'b0);
			{RTYPE, OR}:
				ctrl = mkCtrl(ALU_OR, SEL_REG, 1'b1, 1'b0, 1'b0);
			{RTYPE, XOR}:
				ctrl = mkCtrl(ALU_XOR, SEL_REG, 1'b1, 1'b0, 1'b0);
			{RTYPE, NOR}:
				ctrl = mkCtrl(ALU_NOR, SEL_REG, 1'b1, 1'b0, 1'b0);
			{RTYPE, SLT}:
				ctrl = mkCtrl(ALU_SLT, SEL_REG, 1'b1, 1'b0, 1'b0); // signed compare
			{RTYPE, SLTU}:
				ctrl = mkCtrl(ALU_SLTU, SEL_REG, 1'b1, 1'b0, 1'b0);
			// i-type, funct bits belong to imm
			{ADDI, 6'b??????}:
				ctrl = mkCtrl(ALU_ADD, SEL_IMM, 1'b1, 1'b0, 1'b0);
			{ADDIU, 6'b??????}:
				ctrl = mkCtrl(ALU_ADD, SEL_IMM, 1'b1, 1'b0, 1'b0);
			{SLTI, 6'b??????}:
				ctrl = mkCtrl(ALU_SLT, SEL_IMM, 1'b1, 1'b0, 1'b0);
			{SLTIU, 6'b??????}:
				ctrl = mkCtrl(ALU_SLTU, SEL_IMM, 1'b1, 1'b0, 1'b0); // sign-ext then unsigned
			{ANDI, 6'b??????}:
				ctrl = mkCtrl(ALU_AND, SEL_IMM, 1'b1, 1'b0, 1'b0);
			{ORI, 6'b??????}:
				ctrl = mkCtrl(ALU_OR, SEL_IMM, 1'b1, 1'b0, 1'b0);
			{XORI, 6'b??????}:
				ctrl = mkCtrl(ALU_XOR, SEL_IMM, 1'b1, 1'b0, 1'b0);
			{LUI, 6'b??????}:
				ctrl = mkCtrl(ALU_OR, SEL_IMM, 1'b1, 1'b1, 1'b0); // alu result unused
			{HALT, 6'b??????}:
				ctrl = mkCtrl(ALU_ADD, SEL_REG, 1'b0, 1'b0, 1'b1); // no write
			default:
				ctrl = mkCtrl(ALU_ADD, SEL_REG, 1'b0, 1'b0, 1'b0);
		endcase
	end

	assign decoded = '{
		ctrl: ctrl,
		rs: instr.rs,
		rt: instr.rt,
		destReg: destReg,
		immExt: immExt
	};

endmodule

`default_nettype wire

// File: source/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpuSettings.svh"

module aluUnit
	import cpuPkg::*;
(
	input aluOpT aluOp,
	input wordT a, // rs, or rt for shifts
	input wordT b, // rt, shamt or immediate
	output wordT y
);

	logic [`SHAMT_WIDTH-1:0] shiftAmt;
	logic lessSigned;
	logic lessUnsigned;

	assign shiftAmt = b[`SHAMT_WIDTH-1:0]; // upper bits ignored
	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb
	begin
		case (aluOp)
			ALU_ADD:
				y = a + b; // wraps, no trap
			ALU_SUB:
				y = a - b;
			ALU_AND:
				y = a & b;
			ALU_OR:
				y = a | b;
			ALU_XOR:
				y = a ^ b;
			ALU_NOR:
				y = ~(a | b);
			ALU_SLT:
				y = {{(`DATA_WIDTH-1){1'b0}}, lessSigned}; // 1 or 0
			ALU_SLTU:
				y = {{(`DATA_WIDTH-1){1'b0}}, lessUnsigned};
			ALU_SLL:
				y = a << shiftAmt;
			ALU_SRL:
				y = a >> shiftAmt; // zero fill
			default:
				y = '0; // unused encodings
		endcase
	end

endmodule

`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpuSettings.svh"

module registerFile
	import cpuPkg::*;
(
	input logic CLK,
	input logic rstN,
	input regAddrT rdAddrA,
	input regAddrT rdAddrB,
	output wordT rdDataA,
	output wordT rdDataB,
	input logic wrEn,
	input regAddrT wrAddr,
	input wordT wrData
);

	wordT regs [0:(1 << `REG_ADDR_WIDTH)-1];

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++)
				regs[i] <= '0; // all registers start at zero
		end
		else if (wrEn && (wrAddr != '0))
			regs[wrAddr] <= wrData; // r0 never stored
	end

	// combinational reads, r0 hardwired
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: source/execCore.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpuSettings.svh"

module execCore
	import cpuPkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic req, // four-phase request
	input instrT instr, // stable while req high
	output logic ack,
	output resultT result, // valid while ack high
	output logic halted // sticky until reset
);

	coreStateT state;
	instrT instrReg; // instruction under execution
	decodedT decoded;
	wordT rsValue;
	wordT rtValue;
	wordT aluA;
	wordT aluB;
	wordT aluY;
	wordT wbValue;
	logic wbEn;
	logic wbFire; // the edge that raises ack
	resultT resultNext;

	instrDecoder decoder0 (
		.instr(instrReg),
		.decoded(decoded)
	);

	registerFile regs0 (
		.CLK(CLK),
		.rstN(rstN),
		.rdAddrA(decoded.rs),
		.rdAddrB(decoded.rt),
		.rdDataA(rsValue),
		.rdDataB(rtValue),
		.wrEn(wbFire && wbEn),
		.wrAddr(decoded.destReg),
		.wrData(wbValue)
	);

	aluUnit alu0 (
		.aluOp(decoded.ctrl.aluOp),
		.a(aluA),
		.b(aluB),
		.y(aluY)
	);

	// shifts operate on rt
	assign aluA = (decoded.ctrl.operandSel == SEL_SHAMT) ? rtValue : rsValue;

	always_comb
	begin
		case (decoded.ctrl.operandSel)
			SEL_SHAMT:
				aluB = {{(`DATA_WIDTH-`SHAMT_WIDTH){1'b0}}, instrReg.shamt};
			SEL_IMM:
				aluB = decoded.immExt;
			default:
				aluB = rtValue; // SEL_REG
		endcase
	end

	// lui puts the raw immediate on top, lower half zero
	assign wbValue = decoded.ctrl.isLui ?
		{decoded.immExt[`IMM_WIDTH-1:0], {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}} : aluY;

	// no writes to r0 and none after halt
	assign wbEn = decoded.ctrl.regWrite && (decoded.destReg != '0) && !halted;
	assign wbFire = (state == DONE) && !ack;
	assign resultNext = '{wen: wbEn, destReg: decoded.destReg, value: wbValue};

	// req seen in IDLE -> EXEC -> DONE, ack set on the DONE edge, 2 cycles total
	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			ack <= 1'b0;
			halted <= 1'b0;
			result <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (req)
						state <= EXEC; // instruction latched below
				end
				EXEC:
					state <= DONE; // decode and alu settle here
				DONE:
				begin
					if (!ack)
					begin
						ack <= 1'b1; // same edge as the register write
						result <= resultNext;
						if (decoded.ctrl.isHalt)
							halted <= 1'b1;
					end
					else if (!req)
					begin
						ack <= 1'b0; // requester let go
						state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if ((state == IDLE) && req)
			instrReg <= instr; // held until the next request
	end

endmodule

`default_nettype wire

// File: verif/execCoreTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpuSettings.svh"

module execCoreTb
	import cpuPkg::*;
();

	localparam int clockPeriod = 100; // ns
	localparam int resetCycles = 8;
	localparam int maxInstrs = 300; // upper bound on instructions sent
	localparam int maxInstrCycles = 13; // drive, 3 to ack, 5 held, drop, fall, margin
	localparam int timeoutCycles = resetCycles + maxInstrs * maxInstrCycles;

	typedef logic [`IMM_WIDTH-1:0] immT;
	typedef logic [`SHAMT_WIDTH-1:0] shamtT;

	logic clk;
	logic rstN;
	logic req;
	instrT instr;
	logic ack;
	resultT result;
	logic halted;

	integer seed;
	wordT model [0:(1 << `REG_ADDR_WIDTH)-1]; // expected register contents
	logic modelHalted;
	instrT instrQ [$]; // sent and not yet acknowledged
	string nameQ [$];
	functT rOps [8];
	opcodeT iOps [8];

	execCore dut0 (
		.CLK(clk),
		.rstN(rstN),
		.req(req),
		.instr(instr),
		.ack(ack),
		.result(result),
		.halted(halted)
	);

	always
	begin
		clk = 1'b0;
		#(clockPeriod / 2) clk = 1'b1;
		#(clockPeriod / 2);
	end

	task automatic stopOnFailure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			stopOnFailure();
		end
	endtask

	// destReg and value only where the instruction defines them
	task automatic checkResult(input string name, input resultT expected, input resultT actual,
		input logic known);
		if ((actual.wen !== expected.wen) || (known && ((actual.destReg !== expected.destReg)
			|| (actual.value !== expected.value))))
		begin
			$display("ERROR %s: expected wen %b r%0d %h, actual wen %b r%0d %h", name,
				expected.wen, expected.destReg, expected.value,
				actual.wen, actual.destReg, actual.value);
			stopOnFailure();
		end
	endtask

	function automatic wordT flag(input logic cond);
		return cond ? wordT'(1) : '0;
	endfunction

	// expected writeback from the instruction set rules and the model registers
	function automatic resultT predictResult(input instrT ins, output logic known);
		resultT r;
		wordT s;
		wordT t;
		wordT sext;
		wordT zext;
		immT imm;
		logic writes;
		imm = ins[`IMM_WIDTH-1:0];
		s = model[ins.rs];
		t = model[ins.rt];
		sext = {{(`DATA_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
		zext = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm};
		known = 1'b1;
		writes = 1'b1;
		r.destReg = ins.rt; // i-type target
		r.value = '0;
		case (ins.opcode)
			RTYPE:
			begin
				r.destReg = ins.rd;
				case (ins.funct)
					SLL: r.value = t << ins.shamt;
					SRL: r.value = t >> ins.shamt; // zero fill
					ADD, ADDU: r.value = s + t; // wraps
					SUB, SUBU: r.value = s - t;
					AND: r.value = s & t;
					OR: r.value = s | t;
					XOR: r.value = s ^ t;
					NOR: r.value = ~(s | t);
					SLT: r.value = flag($signed(s) < $signed(t));
					SLTU: r.value = flag(s < t);
					default:
					begin
						writes = 1'b0; // no-op so value undefined
						known = 1'b0;
					end
				endcase
			end
			ADDI, ADDIU: r.value = s + sext;
			SLTI: r.value = flag($signed(s) < $signed(sext));
			SLTIU: r.value = flag(s < sext); // sign-extended then compared unsigned
			ANDI: r.value = s & zext;
			ORI: r.value = s | zext;
			XORI: r.value = s ^ zext;
			LUI: r.value = {imm, {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
			default:
			begin
				writes = 1'b0; // halt and unknown opcodes
				known = 1'b0;
			end
		endcase
		r.wen = writes && (r.destReg != '0) && !modelHalted;
		return r;
	endfunction

	function automatic instrT makeRType(input logic [`FUNCT_WIDTH-1:0] fn, input regAddrT rd,
		input regAddrT rs, input regAddrT rt, input shamtT shamt);
		return {RTYPE, rs, rt, rd, shamt, fn};
	endfunction

	function automatic instrT makeIType(input logic [`OPCODE_WIDTH-1:0] op, input regAddrT rt,
		input regAddrT rs, input immT imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wordT randWord();
		return $random(seed);
	endfunction

	function automatic regAddrT randReg();
		regAddrT r;
		r = regAddrT'($random(seed));
		return (r == '0) ? regAddrT'(1) : r; // r0 has its own tests
	endfunction

	function automatic logic [2:0] pick8();
		return 3'($random(seed));
	endfunction

	// full four-phase cycle with random back-pressure before req drops
	task automatic sendInstr(input string name, input instrT ins);
		resultT held;
		int edges;
		int extra;
		instrQ.push_back(ins);
		nameQ.push_back(name);
		@(posedge clk);
		req <= 1'b1;
		instr <= ins;
		edges = 0;
		do
		begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		while (!ack);
		// one edge samples req and ack comes two edges after that
		if (edges != 3)
		begin
			$display("ERROR %s ack delay: expected %0d edges, actual %0d", name, 3, edges);
			stopOnFailure();
		end
		held = result;
		extra = {$random(seed)} % 6;
		repeat (extra)
		begin
			@(posedge clk);
			@(negedge clk);
			checkBit({name, " ack held"}, 1'b1, ack);
			checkResult({name, " result held"}, held, result, 1'b1);
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		checkBit({name, " ack before fall"}, 1'b1, ack); // req low not sampled yet
		@(negedge clk);
		checkBit({name, " ack fall"}, 1'b0, ack);
	endtask

	task automatic loadReg(input regAddrT r, input wordT value);
		sendInstr("load lui", makeIType(LUI, r, '0, value[`DATA_WIDTH-1:`IMM_WIDTH]));
		sendInstr("load ori", makeIType(ORI, r, r, value[`IMM_WIDTH-1:0]));
	endtask

	// compares each acknowledged instruction and then updates the model
	initial
	begin
		logic ackPrev;
		instrT ins;
		string name;
		resultT expected;
		logic known;
		ackPrev = 1'b0;
		modelHalted = 1'b0;
		foreach (model[i])
			model[i] = '0;
		forever
		begin
			@(negedge clk);
			if ((ack === 1'b1) && (ackPrev !== 1'b1))
			begin
				if (instrQ.size() == 0)
				begin
					$display("ack rose with no request outstanding");
					stopOnFailure();
				end
				else
				begin
					ins = instrQ.pop_front();
					name = nameQ.pop_front();
					expected = predictResult(ins, known);
					checkResult(name, expected, result, known);
					if (ins.opcode == HALT)
						modelHalted = 1'b1; // sticky until reset
					checkBit({name, " halted"}, modelHalted, halted);
					if (expected.wen)
						model[expected.destReg] = expected.value;
				end
			end
			ackPrev = ack;
		end
	end

	initial
	begin
		int cycles;
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= timeoutCycles)
			begin
				$display("timeout after %0d cycles, ack never arrived", cycles);
				stopOnFailure();
			end
		end
	end

	initial
	begin
		regAddrT rd;
		regAddrT rs;
		regAddrT rt;
		logic [2:0] k;
		wordT edgeVals [4];
		seed = 32'h2dfd_d61f;
		rOps = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR};
		iOps = '{ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI};
		edgeVals = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001, 32'hffff_ffff};
		rstN <= 1'b0;
		req <= 1'b0;
		instr <= '0;
		repeat (resetCycles)
			@(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkBit("reset ack", 1'b0, ack);
		checkBit("reset wen", 1'b0, result.wen);
		checkBit("reset halted", 1'b0, halted);
		for (int r = 1; r < 32; r++)
			loadReg(regAddrT'(r), randWord()); // random full words
		repeat (60)
		begin
			k = pick8();
			rd = randReg();
			rs = randReg();
			rt = randReg();
			sendInstr({"rtype ", rOps[k].name()}, makeRType(rOps[k], rd, rs, rt, '0));
		end
		repeat (40)
		begin
			k = pick8();
			rs = randReg();
			rt = randReg();
			sendInstr({"itype ", iOps[k].name()}, makeIType(iOps[k], rt, rs, immT'($random(seed))));
		end
		repeat (16)
		begin
			k = pick8();
			rd = randReg();
			rt = randReg();
			sendInstr(k[0] ? "rtype SLL" : "rtype SRL",
				makeRType(k[0] ? SLL : SRL, rd, '0, rt, shamtT'($random(seed))));
		end
		for (int i = 0; i < 4; i++)
			loadReg(regAddrT'(i + 1), edgeVals[i]); // r1..r4 straddle the sign bit
		for (int i = 1; i <= 4; i++)
		begin
			for (int j = 1; j <= 4; j++)
			begin
				sendInstr("rtype SLT edge", makeRType(SLT, 5'd10, regAddrT'(i), regAddrT'(j), '0));
				sendInstr("rtype SLTU edge", makeRType(SLTU, 5'd11, regAddrT'(i), regAddrT'(j), '0));
			end
		end
		sendInstr("rtype dest r0", makeRType(ADD, '0, randReg(), randReg(), '0));
		sendInstr("itype dest r0", makeIType(ADDI, '0, randReg(), 16'h1234));
		sendInstr("unknown opcode", makeIType(6'h23, randReg(), randReg(), 16'h0010)); // lw
		sendInstr("unknown opcode", makeIType(6'h2b, randReg(), randReg(), 16'h0020)); // sw
		sendInstr("unknown funct", makeRType(6'h08, randReg(), randReg(), randReg(), '0)); // jr
		sendInstr("unknown funct", makeRType(6'h3c, randReg(), randReg(), randReg(), '0));
		sendInstr("read r0", makeIType(ORI, randReg(), '0, '0));
		sendInstr("halt", makeIType(HALT, '0, '0, '0));
		repeat (10)
		begin
			k = pick8();
			rd = randReg();
			rs = randReg();
			rt = randReg();
			sendInstr("after halt", makeRType(rOps[k], rd, rs, rt, '0));
		end
		for (int r = 1; r < 32; r++)
			sendInstr("readback after halt", makeIType(ORI, regAddrT'(r), regAddrT'(r), '0));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/cpuPkg.sv
source/instrDecoder.sv
source/aluUnit.sv
source/registerFile.sv
source/execCore.sv
verif/execCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing -Wall
TOP ?= execCoreTb
FLIST ?= flist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# fails unless the pass message shows up in the output
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "SIMULATION PASSED" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
